// ==== src.f ====
src/scroll_pkg.sv
src/scroll_regs.sv
src/scroll_renderer.sv
src/line_buffer.sv
src/scroll_layer_top.sv
tests/video_clock_gen.sv
tests/scroll_layer_properties.sv
tests/scroll_layer_tb.sv

// ==== Bender.yml ====
package:
  name: scroll_layer

sources:
  - src/scroll_pkg.sv
  - src/scroll_regs.sv
  - src/scroll_renderer.sv
  - src/line_buffer.sv
  - src/scroll_layer_top.sv
  - target: test
    files:
      - tests/video_clock_gen.sv
      - tests/scroll_layer_properties.sv
      - tests/scroll_layer_tb.sv

// ==== tests/scroll_layer_tb.sv ====
// Scroll layer testbench
`default_nettype none

module scroll_layer_tb
    import scroll_pkg::*;
();

    localparam int  tb_model   = model_s16a;
    localparam int  tb_pxl_dly = 0;
    localparam int  tb_hb_end  = 'h70;
    localparam time dly        = 4;        // drive point after the rising edge
    localparam int  apb_limit  = 16;
    localparam int  line_limit = 20000;    // cycles for one rendered line

    // one stimulus row
    typedef struct packed {
        logic [15:0]     pages;
        logic [8:0]      hscr;
        logic [8:0]      vscr;
        logic [8:0]      rowscr;
        logic            rowscr_en;
        logic            flip;
        logic [8:0]      vrender;
        logic            stall;            // random ok back-pressure
        logic            late;             // register write during the line
        logic [3:0][8:0] cols;             // hdump values sampled
    } row_t;

    logic               clk, rst;
    logic               psel, penable, pwrite;
    logic [11:0]        paddr;
    logic [31:0]        pwdata, prdata;
    logic               pready, pslverr;
    logic               pxl2_cen, lhbl;
    logic [8:0]         vrender, hdump;
    logic [map_aw-1:0]  map_addr;
    logic               map_ok;
    logic [15:0]        map_data;
    logic [tile_aw-1:0] tile_addr;
    logic               tile_ok;
    logic [31:0]        tile_data;
    pxl_t               pxl;
    logic               line_done;

    row_t        rows[$];
    logic        stall_on;
    logic [31:0] rng;                      // ok stall source
    int          n_checks, n_mismatch, n_fail, n_assert;

    video_clock_gen #(.period(40), .rst_cycles(16)) clock_i (.clk(clk), .rst(rst));

    scroll_layer_top #(
        .model   (tb_model),
        .pxl_dly (tb_pxl_dly),
        .hb_end  (tb_hb_end)
    ) dut_i (.*);

    // fibonacci lfsr, taps 32 22 2 1, new bit enters at lsb
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] map_word(input logic [map_aw-1:0] addr);
        logic [31:0] prod;
        prod = 32'(addr) * 32'h0000_09e3;
        return prod[15:0];
    endfunction

    // 32 lfsr bits, state seeded from the address and 7
    function automatic logic [31:0] tile_word(input logic [tile_aw-1:0] addr);
        logic [31:0] s;
        logic [31:0] w;
        s = {addr, 15'd7};
        w = '0;
        for (int i = 0; i < 32; i++) begin
            s = lfsr_step(s);
            w = {w[30:0], s[0]};
        end
        return w;
    endfunction

    // distinct word per register so aliased registers read back wrong
    function automatic logic [31:0] reg_pattern(input logic [31:0] pat, input int i);
        return pat ^ (32'(i) * 32'h0000_0123);
    endfunction

    // expected pixel for one dump column of row r
    function automatic pxl_t expect_pixel(input int r, input logic [8:0] hd);
        logic [8:0]        col, eff, vline, vs;
        logic [9:0]        hs;
        logic [3:0]        page;
        logic [map_aw-1:0] maddr;
        logic [15:0]       mw;
        logic [12:0]       code;
        logic [7:0]        attr;
        logic [31:0]       tw;
        logic [2:0]        s;
        col   = rows[r].flip ? 9'h0b0 - hd : hd;      // mirrored read column
        eff   = rows[r].rowscr_en ? rows[r].rowscr : rows[r].hscr;
        hs    = 10'(col) + 10'(eff) + 10'(tb_pxl_dly);
        vline = rows[r].flip ? 9'd223 - rows[r].vrender : rows[r].vrender;
        vs    = vline + rows[r].vscr;
        case ({vs[8], hs[9]})                        // vertical, horizontal carry
            2'b00:   page = rows[r].pages[7:4];
            2'b01:   page = rows[r].pages[3:0];
            2'b10:   page = rows[r].pages[15:12];
            default: page = rows[r].pages[11:8];
        endcase
        if (tb_model == model_s16a) begin
            page[3] = 1'b0;
        end
        maddr = {page, vs[7:3], hs[8:3]};
        mw    = map_word(maddr);
        // s16a bank bit sits at 13, above the palette bit
        code  = (tb_model == model_s16a) ? {mw[13], mw[11:0]} : mw[12:0];
        attr  = (tb_model == model_s16a) ? mw[12:5] : {mw[15], mw[12:6]};
        tw    = tile_word({code, vs[2:0], 1'b0});
        s     = hs[2:0];
        return {attr, tw[23 - s], tw[15 - s], tw[7 - s]};
    endfunction

    task automatic check_pxl(input string name, input pxl_t got, input pxl_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one APB transfer, entered and left at the drive point
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        int n;
        n       = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #dly;
        penable = 1'b1;                              // enable phase
        while (!pready && n < apb_limit) begin
            @(posedge clk);
            #dly;
            n++;
        end
        if (!pready) begin
            n_fail++;
            $display("timeout: no pready for APB access at offset %h", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #dly;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    // outputs while rst is still high
    task automatic check_reset_values();
        @(posedge clk);
        #dly;
        if (rst !== 1'b1) begin
            n_fail++;
            $display("reset was not asserted after the first clock edge");
        end
        check_pxl("pxl", pxl, '0);
        check_flag("pready", pready, 1'b0);
        check_flag("pslverr", pslverr, 1'b0);
        check_flag("line_done", line_done, 1'b0);
        check_word("map_addr", 32'(map_addr), 32'd0);
        check_word("tile_addr", 32'(tile_addr), 32'd0);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst !== 1'b0 && n < 64);
        #dly;
        if (rst !== 1'b0) begin
            n_fail++;
            $display("timeout: reset never released");
        end
    endtask

    // mapped fields zero-extended, unmapped offsets error and read zero
    task automatic test_registers();
        logic [11:0] offs [5];
        logic [31:0] masks [5];
        logic [11:0] bad [3];
        logic [31:0] pats [2];
        logic [31:0] rdata;
        logic        err;
        offs  = '{reg_pages, reg_hscr, reg_vscr, reg_rowscr, reg_ctrl};
        masks = '{32'h0000_ffff, 32'h0000_01ff, 32'h0000_01ff, 32'h0000_01ff, 32'h3};
        bad   = '{12'h014, 12'h002, 12'hffc};
        pats  = '{32'hffff_ffff, 32'h2b6c_a5d1};    // ctrl gets both bits, then flip alone
        foreach (pats[p]) begin
            foreach (offs[i]) write_reg(offs[i], reg_pattern(pats[p], i));
            foreach (offs[i]) begin
                apb_access(1'b0, offs[i], 32'd0, rdata, err);
                check_flag("pslverr", err, 1'b0);
                check_word("prdata", rdata, reg_pattern(pats[p], i) & masks[i]);
            end
        end
        foreach (bad[i]) begin
            apb_access(1'b1, bad[i], 32'hffff_ffff, rdata, err);
            check_flag("pslverr on write", err, 1'b1);
            apb_access(1'b0, bad[i], 32'd0, rdata, err);
            check_flag("pslverr on read", err, 1'b1);
            check_word("prdata", rdata, 32'd0);
        end
        foreach (offs[i]) begin                      // untouched by the bad writes
            apb_access(1'b0, offs[i], 32'd0, rdata, err);
            check_word("prdata", rdata, reg_pattern(pats[1], i) & masks[i]);
        end
    endtask

    task automatic program_row(input int r);
        write_reg(reg_pages, {16'd0, rows[r].pages});
        write_reg(reg_hscr, {23'd0, rows[r].hscr});
        write_reg(reg_vscr, {23'd0, rows[r].vscr});
        write_reg(reg_rowscr, {23'd0, rows[r].rowscr});
        write_reg(reg_ctrl, {30'd0, rows[r].rowscr_en, rows[r].flip});
    endtask

    // short blanking pulse, the falling edge starts a line and swaps banks
    task automatic start_line();
        lhbl = 1'b0;
        repeat (8) @(posedge clk);
        #dly;
        lhbl = 1'b1;
    endtask

    task automatic wait_line_done(input int r);
        int n;
        n = 0;
        while (!line_done && n < line_limit) begin
            @(posedge clk);
            #dly;
            n++;
        end
        if (!line_done) begin
            n_fail++;
            $display("timeout: line_done never rose for table row %0d", r);
        end
    endtask

    // read once for the pixel, hold for a second read that sees the erase
    task automatic read_column(input int r, input logic [8:0] col);
        hdump = col;
        @(posedge clk);
        #dly;
        check_pxl($sformatf("pxl hdump %0d", col), pxl, expect_pixel(r, col));
        @(posedge clk);
        #dly;
        check_pxl($sformatf("pxl hdump %0d reread", col), pxl, '0);
        hdump = rows[r].flip ? 9'h0b0 : 9'h000;     // park on buffer column 0
    endtask

    task automatic run_row(input int r);
        hdump    = rows[r].flip ? 9'h0b0 : 9'h000;
        vrender  = rows[r].vrender;
        stall_on = rows[r].stall;
        program_row(r);
        start_line();
        if (rows[r].late) begin                      // lands in the following line
            write_reg(reg_hscr, {23'd0, rows[r].hscr ^ 9'h0aa});
            write_reg(reg_pages, {16'd0, ~rows[r].pages});
        end
        wait_line_done(r);
        start_line();                                // rendered bank now shown
        for (int c = 3; c >= 0; c--) begin
            read_column(r, rows[r].cols[c]);
        end
    endtask

    // memory models, pixel strobe and ok stalls
    initial begin
        pxl2_cen  = 1'b0;
        map_ok    = 1'b1;
        tile_ok   = 1'b1;
        map_data  = '0;
        tile_data = '0;
        rng       = 32'd7;
        forever begin
            @(posedge clk);
            #dly;
            pxl2_cen = ~pxl2_cen;                    // every other cycle
            if (stall_on) begin
                rng     = lfsr_step(rng);
                map_ok  = rng[0];
                rng     = lfsr_step(rng);
                tile_ok = rng[0];
            end else begin
                map_ok  = 1'b1;
                tile_ok = 1'b1;
            end
            map_data  = map_word(map_addr);
            tile_data = tile_word(tile_addr);
        end
    end

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lhbl       = 1'b1;
        vrender    = '0;
        hdump      = '0;
        stall_on   = 1'b0;
        n_checks   = 0;
        n_mismatch = 0;
        n_fail     = 0;
        n_assert   = 0;
        // pages hscr vscr rowscr en flip vrender stall late, hdump samples
        rows.push_back(row_t'{16'h0000, 9'h000, 9'h000, 9'h000, 1'b0, 1'b0, 9'd16,
                              1'b0, 1'b0, {9'd104, 9'd105, 9'd200, 9'd511}});
        rows.push_back(row_t'{16'h7531, 9'h0f3, 9'h0a5, 9'h000, 1'b0, 1'b0, 9'd60,
                              1'b0, 1'b0, {9'd110, 9'd260, 9'd333, 9'd480}});
        rows.push_back(row_t'{16'he9c3, 9'h170, 9'h0c0, 9'h000, 1'b0, 1'b0, 9'd100,
                              1'b0, 1'b0, {9'd104, 9'd150, 9'd300, 9'd447}});
        rows.push_back(row_t'{16'h1357, 9'h055, 9'h033, 9'h1f8, 1'b1, 1'b0, 9'd200,
                              1'b1, 1'b0, {9'd107, 9'd222, 9'd400, 9'd509}});
        rows.push_back(row_t'{16'h1234, 9'h021, 9'h010, 9'h000, 1'b0, 1'b1, 9'd30,
                              1'b0, 1'b0, {9'd0, 9'd40, 9'd72, 9'd300}});
        rows.push_back(row_t'{16'h2461, 9'h0c7, 9'h19a, 9'h000, 1'b0, 1'b0, 9'd150,
                              1'b1, 1'b1, {9'd120, 9'd250, 9'd380, 9'd505}});
        rows.push_back(row_t'{16'h5a3c, 9'h000, 9'h1e0, 9'h0ff, 1'b1, 1'b1, 9'd223,
                              1'b1, 1'b0, {9'd10, 9'd60, 9'd180, 9'd450}});
        check_reset_values();
        wait_reset();
        test_registers();
        for (int r = 0; r < rows.size(); r++) begin
            run_row(r);
        end
        n_assert = dut_i.renderer_i.render_props_i.n_err
                 + dut_i.regs_i.apb_props_i.n_err;
        $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
                 n_checks, n_mismatch, n_fail, n_assert);
        if (n_mismatch == 0 && n_fail == 0 && n_assert == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/scroll_layer_properties.sv ====
// Scroll layer bound assertions
`default_nettype none

module scroll_layer_properties (
    input wire        clk,
    input wire        rst,
    input wire        pxl2_cen,
    input wire  [1:0] map_st,
    input wire        map_ok,
    input wire [14:0] map_addr,
    input wire        we,
    input wire        line_done,
    input wire        penable,
    input wire        pslverr
);

    int n_err = 0;               // failed assertions so far

    // sequencer parked in state 3 until the map read is ok
    map_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (map_st == 2'd3 && !map_ok) |=> $stable(map_addr))
        else begin
            n_err++;
            $error("map_addr moved while the map read was pending");
        end

    // line buffer writes on pixel strobes of a line still running
    we_in_shift: assert property (@(posedge clk) disable iff (rst)
        we |-> (pxl2_cen && !line_done))
        else begin
            n_err++;
            $error("line buffer write off a pixel strobe or after the line ended");
        end

    // error response only in the enable phase
    err_in_enable: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> penable)
        else begin
            n_err++;
            $error("pslverr raised without penable");
        end

endmodule

// renderer side, APB inputs tied quiet
bind scroll_renderer scroll_layer_properties render_props_i (
    .clk       (clk),
    .rst       (rst),
    .pxl2_cen  (pxl2_cen),
    .map_st    (map_st),
    .map_ok    (map_ok),
    .map_addr  (map_addr),
    .we        (we),
    .line_done (line_done),
    .penable   (1'b1),
    .pslverr   (1'b0)
);

// register side, renderer inputs tied quiet
bind scroll_regs scroll_layer_properties apb_props_i (
    .clk       (clk),
    .rst       (rst),
    .pxl2_cen  (1'b1),
    .map_st    (2'd0),
    .map_ok    (1'b1),
    .map_addr  (15'd0),
    .we        (1'b0),
    .line_done (1'b0),
    .penable   (penable),
    .pslverr   (pslverr)
);

`default_nettype wire

// ==== tests/video_clock_gen.sv ====
// Video clock and reset
`default_nettype none

module video_clock_gen #(
    parameter int period     = 40,
    parameter int rst_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // async reset, released just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #(period / 8);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/scroll_layer_top.sv ====
// Scroll tile layer top
`default_nettype none

module scroll_layer_top
    import scroll_pkg::*;
#(
    parameter int model   = model_s16a,
    parameter int pxl_dly = 0,
    parameter int hb_end  = 'h70
) (
    input  wire                 clk,
    input  wire                 rst,
    // APB
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire  [11:0]         paddr,
    input  wire  [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    // video timing
    input  wire                 pxl2_cen,
    input  wire                 lhbl,
    input  wire  [8:0]          vrender,
    input  wire  [8:0]          hdump,
    // map memory
    output logic [map_aw-1:0]   map_addr,
    input  wire                 map_ok,
    input  wire  [15:0]         map_data,
    // tile memory
    output logic [tile_aw-1:0]  tile_addr,
    input  wire                 tile_ok,
    input  wire  [31:0]         tile_data,
    // pixel out
    output pxl_t                pxl,
    output logic                line_done
);

    logic [15:0] pages;
    logic [8:0]  hscr, vscr, rowscr;
    logic        rowscr_en, flip;
    logic [8:0]  wr_addr;
    pxl_t        wr_data;
    logic        we;
    logic [8:0]  rd_addr;

    // dump column, mirrored around 0xb0 when flipped
    assign rd_addr = flip ? 9'hb0 - hdump : hdump;

    scroll_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pages     (pages),
        .hscr      (hscr),
        .vscr      (vscr),
        .rowscr    (rowscr),
        .rowscr_en (rowscr_en),
        .flip      (flip)
    );

    scroll_renderer #(
        .model   (model),
        .pxl_dly (pxl_dly),
        .hb_end  (hb_end)
    ) renderer_i (
        .clk       (clk),
        .rst       (rst),
        .pxl2_cen  (pxl2_cen),
        .lhbl      (lhbl),
        .vrender   (vrender),
        .pages     (pages),
        .hscr      (hscr),
        .vscr      (vscr),
        .rowscr    (rowscr),
        .rowscr_en (rowscr_en),
        .flip      (flip),
        .map_ok    (map_ok),
        .map_data  (map_data),
        .map_addr  (map_addr),
        .tile_ok   (tile_ok),
        .tile_data (tile_data),
        .tile_addr (tile_addr),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .we        (we),
        .line_done (line_done)
    );

    line_buffer #(
        .aw (9)                      // full 512 column line
    ) linebuf_i (
        .clk     (clk),
        .rst     (rst),
        .lhbl    (lhbl),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .we      (we),
        .rd_addr (rd_addr),
        .rd_data (pxl)
    );

endmodule

`default_nettype wire

// ==== src/line_buffer.sv ====
// Double line buffer
`default_nettype none

module line_buffer
    import scroll_pkg::*;
#(
    parameter int aw = 9
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           lhbl,
    // renderer side
    input  wire  [aw-1:0] wr_addr,
    input  wire  pxl_t    wr_data,
    input  wire           we,
    // dump side, read then erase
    input  wire  [aw-1:0] rd_addr,
    output pxl_t          rd_data
);

    logic lhbl_l;
    logic wbank;                  // bank being rendered, the other is shown
    pxl_t bank_rd [2];            // read word of each bank

    // swap on every blanking start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l <= 1'b0;
            wbank  <= 1'b0;
        end else begin
            lhbl_l <= lhbl;
            if (lhbl_l && !lhbl) begin
                wbank <= ~wbank;
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        pxl_t mem [1 << aw];

        assign bank_rd[b] = mem[rd_addr];

        // one write port per bank, render or erase
        always_ff @(posedge clk) begin
            if (wbank == 1'(b)) begin
                if (we) begin
                    mem[wr_addr] <= wr_data;
                end
            end else begin
                mem[rd_addr] <= '0;       // old value still read this edge
            end
        end
    end

    // registered read from the display bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= wbank ? bank_rd[0] : bank_rd[1];
        end
    end

endmodule

`default_nettype wire

// ==== src/scroll_renderer.sv ====
// Scroll layer line renderer
`default_nettype none

module scroll_renderer
    import scroll_pkg::*;
#(
    parameter int model   = model_s16a,
    parameter int pxl_dly = 0,
    parameter int hb_end  = 'h70
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pxl2_cen,
    input  wire                 lhbl,
    input  wire  [8:0]          vrender,
    // register block
    input  wire  [15:0]         pages,
    input  wire  [8:0]          hscr,
    input  wire  [8:0]          vscr,
    input  wire  [8:0]          rowscr,
    input  wire                 rowscr_en,
    input  wire                 flip,
    // map memory
    input  wire                 map_ok,
    input  wire  [15:0]         map_data,
    output logic [map_aw-1:0]   map_addr,
    // tile memory
    input  wire                 tile_ok,
    input  wire  [31:0]         tile_data,
    output logic [tile_aw-1:0]  tile_addr,
    // line buffer write side
    output logic [8:0]          wr_addr,
    output pxl_t                wr_data,
    output logic                we,
    output logic                line_done
);

    localparam logic [8:0] hscan0 = 9'(hb_end - 8 - pxl_dly);  // first column drawn
    localparam logic [9:0] hdly   = 10'(pxl_dly);

    logic              lhbl_l, lhbl_fall;
    // per-line copies of the registers
    logic [15:0]       pages_s;
    logic [8:0]        hscr_s, vscr_s, rowscr_s;
    logic              rowscr_en_s;
    logic [8:0]        vscan, hscan;       // line and column being drawn
    logic              run, done, active;
    logic [1:0]        map_st;
    logic [8:0]        eff_scr;
    logic [9:0]        hsum;               // {hov, hpos}
    logic [8:0]        vsum;               // {vov, vpos}
    logic [6:0]        fcol;               // tile column to fetch, with overflow
    logic [3:0]        page;
    map_entry_u        entry;
    logic [12:0]       code;
    logic [attr_w-1:0] attr_nxt, attr;
    logic [2:0]        hsub;               // first pixel within the tile
    logic              shift_on;           // shifter owns a tile
    logic              tile_pend, tile_seen, tile_vld;
    logic [7:0]        plane2, plane1, plane0;
    logic              draw, capture, shift;

    assign lhbl_fall = lhbl_l & ~lhbl;
    assign active    = run & ~lhbl_fall;
    assign eff_scr   = rowscr_en_s ? rowscr_s : hscr_s;   // row scroll wins
    assign hsum      = {1'b0, hscan} + {1'b0, eff_scr} + hdly;
    assign vsum      = vscan + vscr_s;
    // next tile while the shifter is busy, current one otherwise
    assign fcol      = hsum[9:3] + {6'd0, shift_on};

    // page from the two overflow bits
    always_comb begin
        case ({vsum[8], fcol[6]})
            2'b10:   page = pages_s[15:12];   // upper left
            2'b11:   page = pages_s[11:8];    // upper right
            2'b00:   page = pages_s[7:4];     // lower left
            default: page = pages_s[3:0];     // lower right
        endcase
        if (model == model_s16a) begin
            page[3] = 1'b0;                   // only eight pages on s16a
        end
    end

    // map word decode
    assign entry = map_entry_u'(map_data);
    always_comb begin
        if (model == model_s16a) begin
            code     = {entry.a.bank, entry.a.code};
            attr_nxt = entry.w[12:5];
        end else begin
            code     = entry.b.code;
            attr_nxt = {entry.b.prio, entry.w[12:6]};
        end
    end

    assign draw    = active & (map_st == 2'd3) & map_ok & tile_ok & ~shift_on;
    assign capture = active & tile_pend & tile_seen;   // one cycle after tile_ok
    assign shift   = active & shift_on & tile_vld & pxl2_cen;

    assign we        = shift;
    assign wr_addr   = hscan;
    assign wr_data   = {attr, plane2[7], plane1[7], plane0[7]};
    assign line_done = done;

    // line control, map sequencer and tile handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l      <= 1'b0;
            pages_s     <= '0;
            hscr_s      <= '0;
            vscr_s      <= '0;
            rowscr_s    <= '0;
            rowscr_en_s <= 1'b0;
            vscan       <= '0;
            hscan       <= '0;
            run         <= 1'b0;
            done        <= 1'b0;
            map_st      <= '0;
            map_addr    <= '0;
            tile_addr   <= '0;
            shift_on    <= 1'b0;
            tile_pend   <= 1'b0;
            tile_seen   <= 1'b0;
            tile_vld    <= 1'b0;
        end else begin
            lhbl_l <= lhbl;
            if (lhbl_fall) begin              // new line, drop anything in flight
                pages_s     <= pages;
                hscr_s      <= hscr;
                vscr_s      <= vscr;
                rowscr_s    <= rowscr;
                rowscr_en_s <= rowscr_en;
                vscan       <= flip ? 9'd223 - vrender : vrender;
                hscan       <= hscan0;
                run         <= 1'b1;
                done        <= 1'b0;
                map_st      <= '0;
                shift_on    <= 1'b0;
                tile_pend   <= 1'b0;
                tile_vld    <= 1'b0;
            end else if (run) begin
                case (map_st)
                    2'd0: begin
                        map_addr <= {page, vsum[7:3], fcol[5:0]};
                        map_st   <= 2'd1;
                    end
                    2'd3: if (draw) begin     // otherwise hold here
                        tile_addr <= {code, vsum[2:0], 1'b0};
                        shift_on  <= 1'b1;
                        tile_pend <= 1'b1;
                        tile_seen <= 1'b0;
                        tile_vld  <= 1'b0;
                        map_st    <= 2'd0;
                    end
                    default: map_st <= map_st + 2'd1;
                endcase
                if (tile_pend) begin
                    tile_seen <= tile_ok;
                    if (capture) begin
                        tile_pend <= 1'b0;
                        tile_vld  <= 1'b1;
                    end
                end
                if (shift) begin
                    hscan <= hscan + 9'd1;
                    if (hsum[2:0] == 3'd7) begin  // last pixel of this tile
                        shift_on <= 1'b0;
                        tile_vld <= 1'b0;
                    end
                    if (&hscan) begin
                        done <= 1'b1;
                        run  <= 1'b0;
                    end
                end
            end
        end
    end

    // pixel payload
    always_ff @(posedge clk) begin
        if (draw) begin
            attr <= attr_nxt;
            hsub <= hsum[2:0];
        end
        if (capture) begin                    // skip pixels left of the scan
            plane2 <= tile_data[23:16] << hsub;
            plane1 <= tile_data[15:8] << hsub;
            plane0 <= tile_data[7:0] << hsub;
        end else if (shift) begin
            plane2 <= plane2 << 1;
            plane1 <= plane1 << 1;
            plane0 <= plane0 << 1;
        end
    end

endmodule

`default_nettype wire

// ==== src/scroll_regs.sv ====
// Scroll layer APB registers
`default_nettype none

module scroll_regs
    import scroll_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // APB slave
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [11:0] paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // to the renderer
    output logic [15:0] pages,
    output logic [8:0]  hscr,
    output logic [8:0]  vscr,
    output logic [8:0]  rowscr,
    output logic        rowscr_en,
    output logic        flip
);

    reg_addr_e   addr;
    logic        mapped;         // offset hits a register
    logic [31:0] rd_word;        // readback before the flop
    logic        setup;          // first APB cycle
    logic        wr_en;

    assign addr  = reg_addr_e'(paddr);
    assign setup = psel & ~penable;
    assign wr_en = psel & penable & pwrite & mapped;  // commit in enable phase

    // address decode and readback mux
    always_comb begin
        mapped  = 1'b1;
        rd_word = '0;
        case (addr)
            reg_pages:  rd_word = {16'd0, pages};
            reg_hscr:   rd_word = {23'd0, hscr};
            reg_vscr:   rd_word = {23'd0, vscr};
            reg_rowscr: rd_word = {23'd0, rowscr};
            reg_ctrl:   rd_word = {30'd0, rowscr_en, flip};
            default:    mapped  = 1'b0;   // reads back zero
        endcase
    end

    // response is set up during the setup phase so pready lands in enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pready  <= setup;
            pslverr <= setup & ~mapped;
            if (setup) begin
                prdata <= pwrite ? 32'd0 : rd_word;
            end
        end
    end

    // register file
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pages     <= '0;
            hscr      <= '0;
            vscr      <= '0;
            rowscr    <= '0;
            rowscr_en <= 1'b0;
            flip      <= 1'b0;
        end else if (wr_en) begin
            case (addr)
                reg_pages:  pages  <= pwdata[15:0];
                reg_hscr:   hscr   <= pwdata[8:0];
                reg_vscr:   vscr   <= pwdata[8:0];
                reg_rowscr: rowscr <= pwdata[8:0];
                reg_ctrl: begin
                    flip      <= pwdata[0];
                    rowscr_en <= pwdata[1];
                end
                default: ;                   // unmapped, nothing stored
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/scroll_pkg.sv ====
// Scroll layer shared definitions
`default_nettype none

package scroll_pkg;

    // tilemap formats
    localparam int model_s16a = 0;       // 3-bit pages plus bank bit
    localparam int model_s16b = 1;       // 4-bit pages, 13-bit code

    // external memory address widths
    localparam int map_aw  = 15;         // page + 5 row + 6 column bits
    localparam int tile_aw = 17;         // code + 3 line bits + half select

    // pixel layout, msb first
    localparam int pri_w  = 1;
    localparam int pal_w  = 7;
    localparam int col_w  = 3;
    localparam int attr_w = pri_w + pal_w;   // what the map entry supplies
    localparam int pxl_w  = attr_w + col_w;

    typedef logic [pxl_w-1:0] pxl_t;     // {prio, palette, colour}

    // APB register offsets, word aligned
    typedef enum logic [11:0] {
        reg_pages  = 12'h000,            // four page nibbles
        reg_hscr   = 12'h004,
        reg_vscr   = 12'h008,
        reg_rowscr = 12'h00c,
        reg_ctrl   = 12'h010             // bit 0 flip, bit 1 row scroll enable
    } reg_addr_e;

    // one map word, two board decodes
    // s16a palette field overlaps the code, so it comes from w[12:5]
    typedef union packed {
        logic [15:0] w;
        struct packed {
            logic        prio;
            logic        rsvd;
            logic        bank;           // code bit 12 on s16a
            logic        pal_hi;
            logic [11:0] code;
        } a;
        struct packed {
            logic        prio;
            logic [1:0]  rsvd;
            logic [12:0] code;
        } b;
    } map_entry_u;

endpackage

`default_nettype wire
